/* bench/xgtx_stim.txt */
// Ten hex words per record: test kind cycles rst pll_lock cdr_lock reset_done e0 e1 e2
// Kind 1 check after cycles: e0 lane ctrl, e1 phy fault, e2 lock status
// Kinds 2 ready, 3 full reset, 4 fault == e2: allowed cycles e0 to e1, cycles is the limit
// Kind 5 random CDR lock and reset done for cycles steps, kind 0 ends the list

// Reset with PLL lock low, 16 cycles then released
1 1 7  1 0 0 0 3DE 3  0
1 1 7  1 0 3 3 3DE 3  3
1 1 4  0 0 3 3 3DE 3  3

// First lock, release order and ready window
2 2 50 0 1 3 3 33  3B 0
2 1 2  0 1 3 3 021 0  7

// Lock loss back to full reset, then relock
3 3 10 0 0 3 3 1   5  0
3 1 2  0 0 3 3 3DE 3  3
3 2 50 0 1 3 3 33  3B 0
3 1 2  0 1 3 3 021 0  7

// CDR lock drop on lane 0, then on lane 1
4 1 0  0 1 2 3 021 1  6
4 1 5  0 1 2 3 021 1  6
4 4 8  0 1 3 3 3   4  0
4 1 3  0 1 3 3 021 0  7
4 1 0  0 1 1 3 021 2  5
4 1 5  0 1 1 3 021 2  5
4 4 8  0 1 3 3 3   4  0
4 1 3  0 1 3 3 021 0  7

// Random lock qualification
5 5 20 0 1 3 3 0   0  0

// End of records
0 0 0  0 0 0 0 0   0  0

/* files.f */
hdl/xgtx_pkg.sv
hdl/pll_lock_sync.sv
hdl/seq_timer.sv
hdl/tx_reset_fsm.sv
hdl/lane_status.sv
hdl/xgtx_reset_ctrl.sv
bench/tb_xgtx_reset_ctrl.sv

/* bench/tb_xgtx_reset_ctrl.sv */
/*
 * Self-checking testbench for the transceiver reset controller.
 * Two lanes with a short sequencing interval, driven record by
 * record from the stimulus file.
 */
`timescale 1ns/1ps
`default_nettype none

module tb_xgtx_reset_ctrl;
	import xgtx_pkg::*;

	localparam int NDEV            = 2;
	localparam int SEQ_WAIT_CYCLES = 16;

	// Stimulus layout, ten hex words per record
	localparam int REC_WORDS = 10;
	localparam int MAX_RECS  = 32;

	// Record kinds
	localparam int OP_END    = 0;
	localparam int OP_CHECK  = 1;
	localparam int OP_READY  = 2;
	localparam int OP_RESET  = 3;
	localparam int OP_FAULT  = 4;
	localparam int OP_RANDOM = 5;

	// Combinational paths settle well before the next rising edge
	localparam time SETTLE = 2;

	logic                                i_wb_clk;
	logic                                pll_reset;
	logic                                i_pll_lock;
	logic [NDEV-1:0]                     i_rx_cdr_lock;
	logic [NDEV-1:0]                     i_rx_reset_done;
	lane_ctrl_t [NDEV-1:0]               lane_ctrl;
	logic [NDEV-1:0]                     phy_fault;
	logic [NDEV:0]                       lock_status;
	logic [NDEV*$bits(lane_ctrl_t)-1:0]  ctrl_flat;

	logic [15:0] stim [REC_WORDS*MAX_RECS];
	logic [15:0] lfsr_state;

	int cycle_cnt    = 0;
	int cycle_limit  = 0;
	int cur_test     = 0;
	int test_checks  = 0;
	int test_errors  = 0;
	int total_checks = 0;
	int total_errors = 0;
	int tests_done   = 0;

	xgtx_reset_ctrl #(
		.NDEV            (NDEV),
		.SEQ_WAIT_CYCLES (SEQ_WAIT_CYCLES)
	) DUT (
		.i_wb_clk        (i_wb_clk),
		.pll_reset       (pll_reset),
		.i_pll_lock      (i_pll_lock),
		.i_rx_cdr_lock   (i_rx_cdr_lock),
		.i_rx_reset_done (i_rx_reset_done),
		.o_lane_ctrl     (lane_ctrl),
		.o_phy_fault     (phy_fault),
		.o_lock_status   (lock_status)
	);

	// Lane 1 in the upper bits
	assign ctrl_flat = lane_ctrl;

	// 8 ns clock
	initial
	begin
		i_wb_clk = 1'b0;
		forever #4 i_wb_clk = ~i_wb_clk;
	end

	////////////////////////////////////////////////////////////////////////////
	// Helpers
	////////////////////////////////////////////////////////////////////////////

	// Galois LFSR, x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic [15:0] lfsr_step(input logic [15:0] s);
		logic [15:0] n;
		n = s >> 1;
		if (s[0])
			n = n ^ 16'hB400;
		return n;
	endfunction

	// One LFSR step per random bit
	task automatic draw_bit(output logic b);
		b = lfsr_state[0];
		lfsr_state = lfsr_step(lfsr_state);
	endtask

	// Position in the release order, -1 for a pattern outside it
	function automatic int release_stage(input logic [4:0] code);
		case (code)
			5'h1E:   return 0;
			5'h06:   return 1;
			5'h02:   return 2;
			5'h01:   return 3;
			default: return -1;
		endcase
	endfunction

	task automatic flag_failure(input string msg);
		$display("test %0d: %s", cur_test, msg);
		test_errors++;
	endtask

	task automatic compare_value(input string name, input logic [15:0] exp,
		input logic [15:0] got);
		test_checks++;
		if (got !== exp)
		begin
			$display("ERR test %0d %s exp %h got %h", cur_test, name, exp, got);
			test_errors++;
		end
	endtask

	task automatic apply_inputs(input int base);
		pll_reset       = stim[base+3][0];
		i_pll_lock      = stim[base+4][0];
		i_rx_cdr_lock   = stim[base+5][NDEV-1:0];
		i_rx_reset_done = stim[base+6][NDEV-1:0];
	endtask

	task automatic finish_test();
		$display("test %0d: %s, %0d checks, %0d errors", cur_test,
			(test_errors == 0) ? "ok" : "bad", test_checks, test_errors);
		total_checks += test_checks;
		total_errors += test_errors;
		test_checks = 0;
		test_errors = 0;
		tests_done++;
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Record handlers
	////////////////////////////////////////////////////////////////////////////

	// Fixed wait, zero means no clock edge at all
	task automatic run_check(input int base);
		int cyc;
		cyc = stim[base+2];
		@(negedge i_wb_clk);
		apply_inputs(base);
		if (cyc == 0)
			#SETTLE;
		else
			repeat (cyc) @(negedge i_wb_clk);
		compare_value("o_lane_ctrl", stim[base+7], ctrl_flat);
		compare_value("o_phy_fault", stim[base+8], phy_fault);
		compare_value("o_lock_status", stim[base+9], lock_status);
	endtask

	// Bounded wait for ready, for full reset or for a fault pattern
	task automatic wait_window(input int base);
		int   op;
		int   limit;
		int   lo;
		int   hi;
		int   k;
		int   seen;
		int   prev;
		int   s0;
		int   s1;
		logic bad;
		logic hit;

		op    = stim[base+1];
		limit = stim[base+2];
		lo    = stim[base+7];
		hi    = stim[base+8];
		seen  = 0;
		prev  = 0;
		k     = 0;
		bad   = 1'b0;
		@(negedge i_wb_clk);
		apply_inputs(base);
		while ((seen == 0) && !bad && (k < limit))
		begin
			@(negedge i_wb_clk);
			k++;
			s0 = release_stage(lane_ctrl[0]);
			s1 = release_stage(lane_ctrl[1]);
			if (op == OP_READY)
			begin
				// Shared reset, so lanes step as one
				if (s0 != s1)
				begin
					flag_failure("lanes left reset in different cycles");
					bad = 1'b1;
				end
				// One stage per step, never back
				else if ((s0 < prev) || (s0 > prev + 1))
				begin
					flag_failure("reset bits released out of order");
					bad = 1'b1;
				end
				prev = s0;
			end
			case (op)
				OP_READY: hit = (s0 == 3) && (s1 == 3);
				OP_RESET: hit = (s0 == 0) && (s1 == 0);
				default:  hit = (phy_fault == stim[base+9][NDEV-1:0]);
			endcase
			if (hit)
				seen = k;
		end
		test_checks++;
		if (!bad && (seen == 0))
			flag_failure("expected change never came before the wait limit");
		else if (!bad && ((seen < lo) || (seen > hi)))
		begin
			$display("test %0d: change came after %0d cycles, allowed %0d to %0d",
				cur_test, seen, lo, hi);
			test_errors++;
		end
	endtask

	// Random CDR lock and reset done, lock bits are the per-lane AND
	task automatic random_lock(input int base);
		int              n;
		int              k;
		int              j;
		logic            b;
		logic [NDEV-1:0] cdr;
		logic [NDEV-1:0] done;
		logic [NDEV:0]   exp;

		n = stim[base+2];
		for (k = 0; k < n; k++)
		begin
			@(negedge i_wb_clk);
			for (j = 0; j < NDEV; j++)
			begin
				draw_bit(b);
				cdr[j] = b;
				draw_bit(b);
				done[j] = b;
			end
			apply_inputs(base);
			i_rx_cdr_lock   = cdr;
			i_rx_reset_done = done;
			#SETTLE;
			exp = {stim[base+4][0], cdr & done};
			compare_value("o_lock_status", exp, lock_status);
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Main sequence
	////////////////////////////////////////////////////////////////////////////

	initial
	begin
		int   r;
		int   base;
		int   nrec;
		int   total;
		logic ended;

		// Reset held until the stimulus releases it
		pll_reset       = 1'b1;
		i_pll_lock      = 1'b0;
		i_rx_cdr_lock   = '0;
		i_rx_reset_done = '0;
		lfsr_state      = 16'd14;

		$readmemh("bench/xgtx_stim.txt", stim);

		// Count records and cycles up to the end marker
		nrec  = 0;
		total = 0;
		ended = 1'b0;
		while ((nrec < MAX_RECS) && !ended)
		begin
			base = nrec * REC_WORDS;
			if ($isunknown(stim[base+1]) || (stim[base+1] == OP_END))
				ended = 1'b1;
			else
			begin
				total += stim[base+2];
				nrec++;
			end
		end
		if (nrec == 0)
		begin
			$display("stimulus file missing or holds no records");
			total_errors++;
		end
		cycle_limit = 2 * total;

		for (r = 0; r < nrec; r++)
		begin
			base = r * REC_WORDS;
			if (r == 0)
				cur_test = stim[base];
			else if (stim[base] != cur_test)
			begin
				finish_test();
				cur_test = stim[base];
			end
			case (stim[base+1])
				OP_CHECK:                     run_check(base);
				OP_READY, OP_RESET, OP_FAULT: wait_window(base);
				OP_RANDOM:                    random_lock(base);
				default:                      flag_failure("unknown record kind");
			endcase
		end
		if (nrec > 0)
			finish_test();

		$display("totals: %0d tests, %0d checks, %0d errors",
			tests_done, total_checks, total_errors);
		if (total_errors == 0)
			$display("ALL CHECKS PASSED");
		else
			$display("CHECKS FAILED");
		$finish;
	end

	// Watchdog, limit set once the records are counted
	initial
	begin
		wait (cycle_limit != 0);
		while (cycle_cnt < cycle_limit)
		begin
			@(posedge i_wb_clk);
			cycle_cnt++;
		end
		$display("timeout, stimulus still running after %0d cycles", cycle_cnt);
		$display("CHECKS FAILED");
		$finish;
	end

endmodule

`default_nettype wire

/* hdl/xgtx_reset_ctrl.sv */
/*
 * Reset and status controller for a multi-lane 10G transceiver.
 * One lock synchronizer feeds NDEV lanes, each with its own
 * sequencing timer, TX reset sequencer and receive status filter.
 */
`timescale 1ns/1ps
`default_nettype none

module xgtx_reset_ctrl #(
	parameter int NDEV            = 1,
	parameter int SEQ_WAIT_CYCLES = 128
) (
	input  logic                            i_wb_clk,
	input  logic                            pll_reset,
	input  logic                            i_pll_lock,
	input  logic [NDEV-1:0]                 i_rx_cdr_lock,
	input  logic [NDEV-1:0]                 i_rx_reset_done,
	output xgtx_pkg::lane_ctrl_t [NDEV-1:0] o_lane_ctrl,
	output logic [NDEV-1:0]                 o_phy_fault,
	output logic [NDEV:0]                   o_lock_status
);
	import xgtx_pkg::*;

	// Shared transceiver reset, high until PLL lock has settled
	logic gtx_reset;

	////////////////////////////////////////////////////////////////////////////
	// Shared PLL lock handling
	////////////////////////////////////////////////////////////////////////////

	pll_lock_sync u_lock_sync (
		.i_wb_clk    (i_wb_clk),
		.pll_reset   (pll_reset),
		.i_pll_lock  (i_pll_lock),
		.o_gtx_reset (gtx_reset)
	);

	// PLL lock reported raw in the top status bit
	assign o_lock_status[NDEV] = i_pll_lock;

	////////////////////////////////////////////////////////////////////////////
	// Per-lane logic
	////////////////////////////////////////////////////////////////////////////

	for (genvar gk = 0; gk < NDEV; gk++)
	begin : g_lane
		// Sequencer and timer talk over these two
		logic       timer_run;
		logic       step_stb;
		lane_stat_t lane_stat;

		// Interval timer
		seq_timer #(
			.SEQ_WAIT_CYCLES (SEQ_WAIT_CYCLES)
		) u_timer (
			.i_wb_clk   (i_wb_clk),
			.pll_reset  (pll_reset),
			.i_run      (timer_run),
			.o_step_stb (step_stb)
		);

		// TX reset release order
		tx_reset_fsm u_tx_fsm (
			.i_wb_clk    (i_wb_clk),
			.pll_reset   (pll_reset),
			.i_gtx_reset (gtx_reset),
			.i_step_stb  (step_stb),
			.o_timer_run (timer_run),
			.o_ctrl      (o_lane_ctrl[gk])
		);

		// Fault filter and lock qualification
		lane_status u_status (
			.i_wb_clk        (i_wb_clk),
			.i_gtx_reset     (gtx_reset),
			.i_rx_cdr_lock   (i_rx_cdr_lock[gk]),
			.i_rx_reset_done (i_rx_reset_done[gk]),
			.o_stat          (lane_stat)
		);

		// Fan status fields out to the flat vectors
		assign o_phy_fault[gk]   = lane_stat.phy_fault;
		assign o_lock_status[gk] = lane_stat.lock;
	end

endmodule

`default_nettype wire

/* hdl/lane_status.sv */
/*
 * Receive status for one lane.
 * Filters the fault flag so it shows at once and clears only
 * after the lane has stayed clean, and qualifies the CDR lock.
 */
`timescale 1ns/1ps
`default_nettype none

module lane_status (
	input  logic                i_wb_clk,
	input  logic                i_gtx_reset,
	input  logic                i_rx_cdr_lock,
	input  logic                i_rx_reset_done,
	output xgtx_pkg::lane_stat_t o_stat
);
	import xgtx_pkg::*;

	// Raw fault condition, also the asynchronous set of the filter
	logic rx_fault;

	// Fault filter chain, top bit is the reported fault
	logic [SYNC_STAGES-1:0] fault_pipe;

	assign rx_fault = i_gtx_reset || !i_rx_cdr_lock;

	////////////////////////////////////////////////////////////////////////////
	// Fault filter
	////////////////////////////////////////////////////////////////////////////

	// Set at once on a fault, then drain zeros once it is gone
	always_ff @(posedge i_wb_clk or posedge rx_fault)
	begin
		if (rx_fault)
			fault_pipe <= '1;
		else
			fault_pipe <= {fault_pipe[SYNC_STAGES-2:0], 1'b0};
	end

	////////////////////////////////////////////////////////////////////////////
	// Status out
	////////////////////////////////////////////////////////////////////////////

	always_comb
	begin
		o_stat = '0;
		o_stat.phy_fault = fault_pipe[SYNC_STAGES-1];

		// CDR lock only counts once the RX side is out of reset
		o_stat.lock = i_rx_cdr_lock && i_rx_reset_done;
	end

endmodule

`default_nettype wire

/* hdl/tx_reset_fsm.sv */
/*
 * Transmit reset sequencer for one lane.
 * Releases the channel reset, then PMA reset, then PCS reset, one
 * step per timer strobe, and raises TX user ready at the end.
 * Any shared transceiver reset restarts the sequence.
 */
`timescale 1ns/1ps
`default_nettype none

module tx_reset_fsm (
	input  logic                i_wb_clk,
	input  logic                pll_reset,
	input  logic                i_gtx_reset,
	input  logic                i_step_stb,
	output logic                o_timer_run,
	output xgtx_pkg::lane_ctrl_t o_ctrl
);
	import xgtx_pkg::*;

	tx_seq_state_e state;
	tx_seq_state_e state_nxt;

	////////////////////////////////////////////////////////////////////////////
	// Next state
	////////////////////////////////////////////////////////////////////////////

	always_comb
	begin
		state_nxt = state;
		if (i_gtx_reset)
			// Start over on lost PLL lock
			state_nxt = TX_GTX_RESET;
		else if (i_step_stb)
		begin
			case (state)
				TX_GTX_RESET: state_nxt = TX_PMA_RESET;
				TX_PMA_RESET: state_nxt = TX_PCS_RESET;
				TX_PCS_RESET: state_nxt = TX_RUNNING;
				// Stays up until the next shared reset
				default:      state_nxt = TX_RUNNING;
			endcase
		end
	end

	always_ff @(posedge i_wb_clk or posedge pll_reset)
	begin
		if (pll_reset)
			state <= TX_GTX_RESET;
		else
			state <= state_nxt;
	end

	// Timer only runs while there is still a step to take
	assign o_timer_run = !i_gtx_reset && (state != TX_RUNNING);

	////////////////////////////////////////////////////////////////////////////
	// Output decode
	////////////////////////////////////////////////////////////////////////////

	always_comb
	begin
		o_ctrl = '0;

		// Channel reset only in the first state
		o_ctrl.gtx_tx_reset = (state == TX_GTX_RESET);
		// RX reset follows TX with no separate receive chain
		o_ctrl.gtx_rx_reset = o_ctrl.gtx_tx_reset;

		// PMA held through the first two states
		o_ctrl.tx_pma_reset = (state == TX_GTX_RESET) ||
			(state == TX_PMA_RESET);

		// PCS held until the lane runs
		o_ctrl.tx_pcs_reset = (state != TX_RUNNING);
		o_ctrl.tx_user_rdy  = (state == TX_RUNNING);
	end

	////////////////////////////////////////////////////////////////////////////
	// Checks
	////////////////////////////////////////////////////////////////////////////

	// PMA never leaves reset ahead of the channel
	a_pma_after_gtx : assert property (
		@(posedge i_wb_clk) disable iff (pll_reset)
		$fell(o_ctrl.tx_pma_reset) |-> !o_ctrl.gtx_tx_reset
	);

	// PCS never leaves reset ahead of the PMA
	a_pcs_after_pma : assert property (
		@(posedge i_wb_clk) disable iff (pll_reset)
		$fell(o_ctrl.tx_pcs_reset) |-> !o_ctrl.tx_pma_reset
	);

	// Ready only while PCS is out of reset
	a_rdy_vs_pcs : assert property (
		@(posedge i_wb_clk) disable iff (pll_reset)
		o_ctrl.tx_user_rdy == !o_ctrl.tx_pcs_reset
	);

endmodule

`default_nettype wire

/* hdl/seq_timer.sv */
/*
 * Per-lane sequencing timer.
 * Counts down one interval of SEQ_WAIT_CYCLES while the sequencer
 * asks it to run, and emits a single-cycle step strobe per interval.
 */
`timescale 1ns/1ps
`default_nettype none

module seq_timer #(
	parameter int SEQ_WAIT_CYCLES = 128
) (
	input  logic i_wb_clk,
	input  logic pll_reset,
	input  logic i_run,
	output logic o_step_stb
);
	import xgtx_pkg::*;

	// Count loaded at the start of every interval
	localparam seq_count_t RELOAD = seq_count_t'(SEQ_WAIT_CYCLES - 1);

	seq_count_t count;

	// Interval must fit the counter and leave room between strobes
	if ((SEQ_WAIT_CYCLES < 2) || (SEQ_WAIT_CYCLES > (1 << SEQ_CNT_W)))
	begin : g_bad_wait
		$error("seq_timer: SEQ_WAIT_CYCLES out of range");
	end

	////////////////////////////////////////////////////////////////////////////
	// Down-counter and strobe
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge i_wb_clk or posedge pll_reset)
	begin
		if (pll_reset)
		begin
			// Loaded and idle
			count      <= RELOAD;
			o_step_stb <= 1'b0;
		end
		else if (!i_run)
		begin
			// Hold at the top until the sequencer needs a step
			count      <= RELOAD;
			o_step_stb <= 1'b0;
		end
		else
		begin
			// Wrap back to the top so intervals repeat
			if (count == '0)
				count <= RELOAD;
			else
				count <= count - 1'b1;

			// Registered zero detect, one cycle after terminal count
			o_step_stb <= (count == '0);
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Checks
	////////////////////////////////////////////////////////////////////////////

	// Strobe is a pulse, never a level
	a_stb_single : assert property (
		@(posedge i_wb_clk) disable iff (pll_reset)
		o_step_stb |=> !o_step_stb
	);

endmodule

`default_nettype wire

/* hdl/pll_lock_sync.sv */
/*
 * QPLL lock synchronizer.
 * Brings the PLL lock into the i_wb_clk domain and turns its loss
 * into the transceiver reset shared by every lane.
 */
`timescale 1ns/1ps
`default_nettype none

module pll_lock_sync (
	input  logic i_wb_clk,
	input  logic pll_reset,
	input  logic i_pll_lock,
	output logic o_gtx_reset
);
	import xgtx_pkg::*;

	// Oldest sample sits in the top bit
	logic [SYNC_STAGES-1:0] sync_pipe;

	////////////////////////////////////////////////////////////////////////////
	// Lock synchronizer
	////////////////////////////////////////////////////////////////////////////

	// Shift in "not locked", so reset holds until lock has settled
	always_ff @(posedge i_wb_clk or posedge pll_reset)
	begin
		if (pll_reset)
			// Lanes stay in reset from power up
			sync_pipe <= '1;
		else
			sync_pipe <= {sync_pipe[SYNC_STAGES-2:0], !i_pll_lock};
	end

	// Last stage drives every lane
	assign o_gtx_reset = sync_pipe[SYNC_STAGES-1];

	////////////////////////////////////////////////////////////////////////////
	// Checks
	////////////////////////////////////////////////////////////////////////////

	// A lost lock reaches the lanes within the synchronizer depth
	a_lock_loss_resets : assert property (
		@(posedge i_wb_clk) disable iff (pll_reset)
		(!i_pll_lock) [* SYNC_STAGES] |=> o_gtx_reset
	);

endmodule

`default_nettype wire

/* hdl/xgtx_pkg.sv */
/*
 * Shared definitions for the 10G transceiver reset controller.
 * Holds the counter and synchronizer widths, the TX reset sequence
 * states, and the per-lane control and status bundles.
 */
`default_nettype none

package xgtx_pkg;

	////////////////////////////////////////////////////////////////////////////
	// Widths
	////////////////////////////////////////////////////////////////////////////

	// Sequencing counter, allows intervals up to 256 cycles
	localparam int SEQ_CNT_W = 8;

	// Remaining cycles of one sequencing interval
	typedef logic [SEQ_CNT_W-1:0] seq_count_t;

	// Flops in the lock synchronizer and in the fault filter
	localparam int SYNC_STAGES = 3;

	////////////////////////////////////////////////////////////////////////////
	// TX reset sequence
	////////////////////////////////////////////////////////////////////////////

	// Release order, one step per timer strobe
	typedef enum logic [1:0] {
		TX_GTX_RESET = 2'd0,
		TX_PMA_RESET = 2'd1,
		TX_PCS_RESET = 2'd2,
		TX_RUNNING   = 2'd3
	} tx_seq_state_e;

	////////////////////////////////////////////////////////////////////////////
	// Lane bundles
	////////////////////////////////////////////////////////////////////////////

	// Resets and ready going out to one channel
	typedef struct packed {
		logic gtx_tx_reset;
		logic gtx_rx_reset;
		logic tx_pma_reset;
		logic tx_pcs_reset;
		logic tx_user_rdy;
	} lane_ctrl_t;

	// Filtered fault and qualified lock of one lane
	typedef struct packed {
		logic phy_fault;
		logic lock;
	} lane_stat_t;

endpackage

`default_nettype wire
